// File: project.f
design/rv_pkg.sv
design/regfile.sv
design/decoder.sv
design/alu.sv
design/mem_ctrl.sv
design/cpu.sv
tb/ram_model.sv
tb/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_cpu -f project.f -o sim_tb_cpu

./obj_dir/sim_tb_cpu | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    exit 1
fi

// File: tb/tb_cpu.sv
/* Testbench for the RV32I core: program built from an LFSR, reference
   results, two runs (second with pauses), store checks by assertions */
module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk_in;
    logic        rst_in;
    logic        rdy_in;
    logic [7:0]  mem_din_i;
    logic [7:0]  mem_dout_o;
    logic [31:0] mem_addr_o;
    logic        mem_wr_o;
    logic [31:0] dbgreg_dout_o;

    logic [15:0] lfsr_q;
    logic        pause_en;
    logic [31:0] pc_w;
    logic [31:0] char_word;
    logic [7:0]  exp_byte [0:255];
    logic        exp_valid [0:255];
    logic        seen [0:255];
    logic        char_seen;
    logic [31:0] last_wr_addr;
    logic [1:0]  wr_lane;
    int          mismatch_cnt;
    int          timeout_cnt;
    int          missing_cnt;

    cpu uut (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .rdy_in        (rdy_in),
        .mem_din_i     (mem_din_i),
        .mem_dout_o    (mem_dout_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wr_o      (mem_wr_o),
        .dbgreg_dout_o (dbgreg_dout_o)
    );

    ram_model ram (
        .clk_in (clk_in),
        .addr_i (mem_addr_o),
        .din_i  (mem_dout_o),
        .wr_i   (mem_wr_o),
        .dout_o (mem_din_i)
    );

    initial
    begin
        clk_in = 1'b0;
        forever
            #2 clk_in = ~clk_in;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v[i] = lfsr_q[0];
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] w);
        for (int b = 0; b < 4; b++)
            ram.mem[pc_w + b] = w[8*b +: 8];
        pc_w = pc_w + 4;
    endtask

    // result area at 0x400 indexed by the low address byte
    task automatic expect_word(input logic [7:0] ofs, input logic [31:0] w);
        for (int b = 0; b < 4; b++)
        begin
            exp_valid[ofs + b] = 1'b1;
            exp_byte[ofs + b]  = w[8*b +: 8];
        end
    endtask

    function automatic logic write_ok(input logic [31:0] a, input logic [7:0] d);
        if (a[31:8] == 24'h000004)
            return exp_valid[a[7:0]] && exp_byte[a[7:0]] == d;
        else if (a[31:2] == 30'h0000C000)
            return d == char_word[8*a[1:0] +: 8];
        else if (a[31:2] == 30'h0000C001)
            return 1'b1;
        return 1'b0;
    endfunction

    // pause stimulus of about one cycle in four in the second run
    always @(posedge clk_in)
    begin
        logic [31:0] v;
        if (pause_en)
        begin
            v = draw_bits(2);
            rdy_in <= !(v[0] && v[1]);
        end
        else
            rdy_in <= 1'b1;
    end

    // store bookkeeping for the lane order and completeness checks
    always @(posedge clk_in)
    begin
        if (rst_in)
        begin
            wr_lane <= 2'd0;
            for (int i = 0; i < 256; i++)
                seen[i] <= 1'b0;
            char_seen <= 1'b0;
        end
        else if (mem_wr_o)
        begin
            wr_lane      <= wr_lane + 2'd1;
            last_wr_addr <= mem_addr_o;
            if (mem_addr_o[31:8] == 24'h000004)
                seen[mem_addr_o[7:0]] <= 1'b1;
            if (mem_addr_o == 32'h0003_0000)
                char_seen <= 1'b1;
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in)
        mem_wr_o |-> write_ok(mem_addr_o, mem_dout_o))
    else
    begin
        mismatch_cnt++;
        $display("mismatch at %0t: byte %02h stored at %08h", $time,
                 $sampled(mem_dout_o), $sampled(mem_addr_o));
    end

    // low byte first and then consecutive addresses
    assert property (@(posedge clk_in) disable iff (rst_in)
        mem_wr_o |-> (wr_lane == 2'd0 ? mem_addr_o[1:0] == 2'b00
                                      : mem_addr_o == last_wr_addr + 1))
    else
    begin
        mismatch_cnt++;
        $display("mismatch at %0t: store lane %0d at address %08h out of order", $time,
                 $sampled(wr_lane), $sampled(mem_addr_o));
    end

    // reads in the program area are fetches of the word at the pc
    assert property (@(posedge clk_in) disable iff (rst_in)
        (!mem_wr_o && mem_addr_o < 32'h400) |-> mem_addr_o[31:2] == dbgreg_dout_o[31:2])
    else
    begin
        mismatch_cnt++;
        $display("mismatch at %0t: fetch address %08h against pc %08h", $time,
                 $sampled(mem_addr_o), $sampled(dbgreg_dout_o));
    end

    assert property (@(posedge clk_in) disable iff (rst_in) !rdy_in |-> !mem_wr_o)
    else
    begin
        mismatch_cnt++;
        $display("mismatch at %0t: write strobe high during pause", $time);
    end

    assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_in |=> ($stable(mem_addr_o) && $stable(dbgreg_dout_o)))
    else
    begin
        mismatch_cnt++;
        $display("mismatch at %0t: address or pc moved during pause", $time);
    end

    task automatic apply_reset(input logic with_pause);
        @(posedge clk_in);
        rst_in   <= 1'b1;
        pause_en <= 1'b0;
        repeat (10)
            @(posedge clk_in);
        rst_in   <= 1'b0;
        pause_en <= with_pause;
    endtask

    task automatic wait_stop(input int limit);
        int n;
        n = 0;
        while (!(mem_wr_o && mem_addr_o == 32'h0003_0004) && n < limit)
        begin
            @(negedge clk_in);
            n++;
        end
        if (n >= limit)
        begin
            timeout_cnt++;
            $display("timeout: the stop write to 0x30004 never arrived");
        end
    endtask

    task automatic check_complete();
        for (int i = 0; i < 256; i++)
        begin
            if (exp_valid[i] && !seen[i])
            begin
                missing_cnt++;
                $display("store to %08h never happened", 32'h400 + i);
            end
        end
        if (!char_seen)
        begin
            missing_cnt++;
            $display("character was never written to 0x30000");
        end
    endtask

    initial
    begin
        logic [31:0] v;
        logic [11:0] ia, ib, c;
        logic [19:0] u;
        logic [31:0] pre, x1, x2, x3, jal_pc;
        rst_in       = 1'b1;
        rdy_in       = 1'b1;
        pause_en     = 1'b0;
        lfsr_q       = 16'd26745;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        missing_cnt  = 0;
        pc_w         = 32'h0;
        for (int i = 0; i < 256; i++)
            exp_valid[i] = 1'b0;

        v = draw_bits(12);
        ia = v[11:0];
        v = draw_bits(12);
        ib = v[11:0];
        v = draw_bits(20);
        u = v[19:0];
        v = draw_bits(12);
        c = v[11:0];
        pre = draw_bits(32);
        v = draw_bits(5);
        char_word = 32'h40 | v[4:0];

        // reference results from the isa rules
        x1 = sext12(ia);
        x2 = sext12(ib);
        x3 = {u, 12'h000};
        expect_word(8'h00, x1);
        expect_word(8'h04, x2);
        expect_word(8'h08, x3);
        expect_word(8'h0C, x1 + x2);
        expect_word(8'h10, x1 - x2);
        expect_word(8'h14, {31'b0, $signed(x1) < $signed(x2)});
        expect_word(8'h18, x1 ^ x2);
        expect_word(8'h1C, x1 | x2);
        expect_word(8'h20, x1 & x2);
        expect_word(8'h24, x3 + x1);
        expect_word(8'h40, pre + sext12(c));
        expect_word(8'h84, x2);

        // preload for the load round trip
        for (int b = 0; b < 4; b++)
            ram.mem[32'h600 + b] = pre[8*b +: 8];

        emit(enc_i(ia, 5'd0, 3'd0, 5'd1, 7'h13));
        emit(enc_i(ib, 5'd0, 3'd0, 5'd2, 7'h13));
        emit(enc_u(u, 5'd3));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd4));
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd5));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd6));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd7));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd8));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd9));
        emit(enc_r(7'h00, 5'd1, 5'd3, 3'd0, 5'd10));
        emit(enc_i(12'h400, 5'd0, 3'd0, 5'd11, 7'h13));
        for (int k = 1; k <= 10; k++)
            emit(enc_s(12'(4 * (k - 1)), 5'(k), 5'd11));
        emit(enc_i(12'h200, 5'd11, 3'd2, 5'd12, 7'h03));
        emit(enc_i(c, 5'd12, 3'd0, 5'd12, 7'h13));
        emit(enc_s(12'h040, 5'd12, 5'd11));

        // beq taken skips 0x480 and bne falls through to 0x484
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'd0));
        emit(enc_s(12'h080, 5'd1, 5'd11));
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'd1));
        emit(enc_s(12'h084, 5'd2, 5'd11));
        jal_pc = pc_w;
        expect_word(8'h8C, jal_pc + 4);
        emit(enc_j(21'd8, 5'd13));
        emit(enc_s(12'h088, 5'd1, 5'd11));
        emit(enc_s(12'h08C, 5'd13, 5'd11));

        emit(enc_u(20'h00030, 5'd14));
        emit(enc_i(char_word[11:0], 5'd0, 3'd0, 5'd15, 7'h13));
        emit(enc_s(12'h000, 5'd15, 5'd14));
        emit(enc_s(12'h004, 5'd0, 5'd14));
        emit(enc_j(21'd0, 5'd0));

        for (int pass = 0; pass < 2; pass++)
        begin
            apply_reset(pass == 1);
            wait_stop(5000);
            check_complete();
        end

        $display("errors: mismatch %0d, timeout %0d, missing %0d",
                 mismatch_cnt, timeout_cnt, missing_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0 && missing_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: tb/ram_model.sv
/* Byte-wide RAM model of 128 KB with registered read data and a
   monitor for stores into the I/O space */
module ram_model (
    input  logic        clk_in,
    input  logic [31:0] addr_i,
    input  logic [7:0]  din_i,
    input  logic        wr_i,
    output logic [7:0]  dout_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // loaded directly by the testbench before reset releases
    logic [7:0] mem [0:(1<<17)-1];

    logic io_space;

    // bits 17:16 both set select I/O, which has no storage
    assign io_space = (addr_i[17:16] == 2'b11);

    always @(posedge clk_in)
    begin
        if (wr_i && !io_space)
            mem[addr_i[16:0]] <= din_i;
        if (io_space)
            dout_o <= 8'h00;
        else
            dout_o <= mem[addr_i[16:0]];
    end

    // character port shows up in the log
    always @(posedge clk_in)
    begin
        if (wr_i && addr_i == 32'h0003_0000)
            $display("io char write 0x%02h at %0t", din_i, $time);
    end

endmodule

// File: design/cpu.sv
/* RV32I core top: program counter, instruction register, control FSM
   and the wiring of decoder, register file, ALU and memory sequencer */
module cpu #(
    parameter int data_w = rv_pkg::xlen,
    parameter int reg_w  = rv_pkg::reg_addr_w
) (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              rdy_in,
    input  logic [7:0]        mem_din_i,
    output logic [7:0]        mem_dout_o,
    output logic [data_w-1:0] mem_addr_o,
    output logic              mem_wr_o,
    output logic [data_w-1:0] dbgreg_dout_o
);
    import rv_pkg::*;

    cpu_state_e        state_q;
    logic [data_w-1:0] pc_q;
    logic [data_w-1:0] ir_q;
    logic [data_w-1:0] load_q;
    logic              req_q;

    opcode_e           opcode;
    alu_op_e           alu_op;
    logic [reg_w-1:0]  rs1, rs2, rd;
    logic [data_w-1:0] imm;
    logic              use_imm, wreg, is_branch, branch_ne;
    logic [data_w-1:0] rdata1, rdata2;
    logic [data_w-1:0] alu_a, alu_b, alu_result;
    logic              alu_equal;
    logic              branch_taken;
    logic [data_w-1:0] pc_plus4, pc_target, wb_data;
    logic              mem_start, mem_done;
    mem_cmd_e          mem_cmd;
    logic [data_w-1:0] mem_base, mem_rdata;

    assign dbgreg_dout_o = pc_q;

    // operand select, pc feeds the adder for jal
    assign alu_a = (opcode == op_jal) ? pc_q : rdata1;
    assign alu_b = use_imm ? imm : rdata2;

    assign pc_plus4     = pc_q + 4;
    assign pc_target    = pc_q + imm;
    assign branch_taken = is_branch && (alu_equal != branch_ne);

    always_comb
    begin
        case (opcode)
            op_jal:  wb_data = pc_plus4;
            op_load: wb_data = load_q;
            default: wb_data = alu_result;
        endcase
    end

    // one word request per fetch or memory state
    assign mem_start = (state_q == st_fetch || state_q == st_mem) && !req_q;
    assign mem_cmd   = (state_q == st_mem && opcode == op_store) ? cmd_write : cmd_read;
    assign mem_base  = (state_q == st_fetch) ? pc_q : alu_result;

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            state_q <= st_fetch;
            pc_q    <= '0;
            req_q   <= 1'b0;
        end
        else if (rdy_in)
        begin
            if (mem_done)
                req_q <= 1'b0;
            else if (mem_start)
                req_q <= 1'b1;

            case (state_q)
                st_fetch:
                begin
                    if (mem_done)
                        state_q <= st_execute;
                end
                st_execute:
                begin
                    if (opcode == op_load || opcode == op_store)
                        state_q <= st_mem;
                    else
                        state_q <= st_writeback;
                end
                st_mem:
                begin
                    if (mem_done)
                        state_q <= st_writeback;
                end
                default:
                begin
                    // st_writeback, register write happens in this cycle too
                    if (opcode == op_jal)
                        pc_q <= alu_result;
                    else if (branch_taken)
                        pc_q <= pc_target;
                    else
                        pc_q <= pc_plus4;
                    state_q <= st_fetch;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in && mem_done && state_q == st_fetch)
            ir_q <= mem_rdata;
        if (rdy_in && mem_done && state_q == st_mem)
            load_q <= mem_rdata;
    end

    decoder #(.data_w(data_w), .reg_w(reg_w)) u_decoder (
        .inst_i      (ir_q),
        .opcode_o    (opcode),
        .alu_op_o    (alu_op),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .imm_o       (imm),
        .use_imm_o   (use_imm),
        .wreg_o      (wreg),
        .is_branch_o (is_branch),
        .branch_ne_o (branch_ne)
    );

    regfile #(.data_w(data_w), .addr_w(reg_w)) u_regfile (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .rdy_i    (rdy_in),
        .we_i     (state_q == st_writeback && wreg),
        .waddr_i  (rd),
        .wdata_i  (wb_data),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    alu #(.data_w(data_w)) u_alu (
        .op_i     (alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result),
        .equal_o  (alu_equal)
    );

    mem_ctrl #(.data_w(data_w)) u_mem_ctrl (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .rdy_i      (rdy_in),
        .start_i    (mem_start),
        .cmd_i      (mem_cmd),
        .base_i     (mem_base),
        .wdata_i    (rdata2),
        .done_o     (mem_done),
        .rdata_o    (mem_rdata),
        .mem_din_i  (mem_din_i),
        .mem_dout_o (mem_dout_o),
        .mem_addr_o (mem_addr_o),
        .mem_wr_o   (mem_wr_o)
    );

endmodule

// File: design/mem_ctrl.sv
/* Byte-serial memory sequencer: word fetch, word load and word store
   over the 8-bit port, little-endian */
module mem_ctrl #(
    parameter int data_w = rv_pkg::xlen
) (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              rdy_i,
    input  logic              start_i,
    input  rv_pkg::mem_cmd_e  cmd_i,
    input  logic [data_w-1:0] base_i,
    input  logic [data_w-1:0] wdata_i,
    output logic              done_o,
    output logic [data_w-1:0] rdata_o,
    input  logic [7:0]        mem_din_i,
    output logic [7:0]        mem_dout_o,
    output logic [data_w-1:0] mem_addr_o,
    output logic              mem_wr_o
);
    import rv_pkg::*;

    logic              busy_q;
    mem_cmd_e          cmd_q;
    logic [2:0]        cnt_q;
    logic [data_w-1:0] addr_q;
    logic [data_w-1:0] wdata_q;
    logic [data_w-1:0] word_q;
    logic              pend_q;
    logic              active;
    mem_cmd_e          cur_cmd;
    logic              read_issue;

    // byte 0 goes out in the start cycle straight from the request
    assign active     = start_i || busy_q;
    assign cur_cmd    = busy_q ? cmd_q : cmd_i;
    assign mem_addr_o = start_i ? base_i : addr_q;
    assign mem_wr_o   = rdy_i && active && (cur_cmd == cmd_write);
    assign mem_dout_o = busy_q ? wdata_q[8*cnt_q[1:0] +: 8] : wdata_i[7:0];

    // writes end with lane 3 and reads one cycle after their last address
    assign done_o = busy_q && ((cmd_q == cmd_write) ? (cnt_q == 3'd3) : (cnt_q == 3'd4));

    assign read_issue = active && (cur_cmd == cmd_read) && !(busy_q && cnt_q == 3'd4);

    // last byte is forwarded so the word is complete in the done cycle
    assign rdata_o = pend_q ? {mem_din_i, word_q[data_w-1:8]} : word_q;

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            busy_q <= 1'b0;
            cmd_q  <= cmd_read;
            cnt_q  <= '0;
            addr_q <= '0;
        end
        else if (rdy_i)
        begin
            if (start_i && !busy_q)
            begin
                busy_q <= 1'b1;
                cmd_q  <= cmd_i;
                cnt_q  <= 3'd1;
                addr_q <= base_i + 1;
            end
            else if (busy_q)
            begin
                if (done_o)
                    busy_q <= 1'b0;
                else
                begin
                    cnt_q <= cnt_q + 3'd1;
                    // address stays on base+3 while the last read byte returns
                    if (cnt_q < 3'd3)
                        addr_q <= addr_q + 1;
                end
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_i && start_i && !busy_q)
            wdata_q <= wdata_i;
    end

    // the ram answers on every edge so a byte is taken one cycle
    // after its address was accepted whether paused or not
    always_ff @(posedge clk_in)
    begin
        if (rst_in)
            pend_q <= 1'b0;
        else
            pend_q <= rdy_i && read_issue;
    end

    always_ff @(posedge clk_in)
    begin
        if (pend_q)
            word_q <= {mem_din_i, word_q[data_w-1:8]};
    end

    // a pause does not move the address
    assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_i |=> $stable(mem_addr_o));

    // control waits for done before the next word
    assert property (@(posedge clk_in) disable iff (rst_in) busy_q |-> !start_i);

endmodule

// File: design/alu.sv
/* Execute unit: arithmetic and logic result plus operand equality */
module alu #(
    parameter int data_w = rv_pkg::xlen
) (
    input  rv_pkg::alu_op_e   op_i,
    input  logic [data_w-1:0] a_i,
    input  logic [data_w-1:0] b_i,
    output logic [data_w-1:0] result_o,
    output logic              equal_o
);
    import rv_pkg::*;

    logic less;

    // slt compares as two's complement
    assign less = $signed(a_i) < $signed(b_i);

    always_comb
    begin
        case (op_i)
            alu_add:    result_o = a_i + b_i;
            alu_sub:    result_o = a_i - b_i;
            alu_slt:    result_o = {{(data_w-1){1'b0}}, less};
            alu_xor:    result_o = a_i ^ b_i;
            alu_or:     result_o = a_i | b_i;
            alu_and:    result_o = a_i & b_i;
            // lui passes the shifted immediate
            alu_pass_b: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

    // beq/bne decision is made in the control from this flag
    assign equal_o = (a_i == b_i);

endmodule

// File: design/decoder.sv
/* Instruction decoder: opcode class, ALU operation, register fields,
   sign-extended immediate and write/branch flags */
module decoder #(
    parameter int data_w = rv_pkg::xlen,
    parameter int reg_w  = rv_pkg::reg_addr_w
) (
    input  logic [data_w-1:0] inst_i,
    output rv_pkg::opcode_e   opcode_o,
    output rv_pkg::alu_op_e   alu_op_o,
    output logic [reg_w-1:0]  rs1_o,
    output logic [reg_w-1:0]  rs2_o,
    output logic [reg_w-1:0]  rd_o,
    output logic [data_w-1:0] imm_o,
    output logic              use_imm_o,
    output logic              wreg_o,
    output logic              is_branch_o,
    output logic              branch_ne_o
);
    import rv_pkg::*;

    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [data_w-1:0] imm_i_fmt, imm_s_fmt, imm_b_fmt, imm_u_fmt, imm_j_fmt;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rs1_o  = inst_i[15 +: reg_w];
    assign rs2_o  = inst_i[20 +: reg_w];
    assign rd_o   = inst_i[7 +: reg_w];

    assign imm_i_fmt = {{(data_w-11){inst_i[31]}}, inst_i[30:20]};
    assign imm_s_fmt = {{(data_w-11){inst_i[31]}}, inst_i[30:25], inst_i[11:7]};
    assign imm_b_fmt = {{(data_w-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign imm_u_fmt = {{(data_w-31){inst_i[31]}}, inst_i[30:12], 12'b0};
    assign imm_j_fmt = {{(data_w-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

    always_comb
    begin
        // anything not matched below stays a no-op
        opcode_o    = op_other;
        alu_op_o    = alu_add;
        imm_o       = imm_i_fmt;
        use_imm_o   = 1'b0;
        wreg_o      = 1'b0;
        is_branch_o = 1'b0;
        branch_ne_o = 1'b0;
        case (inst_i[6:0])
            op_lui:
            begin
                opcode_o  = op_lui;
                alu_op_o  = alu_pass_b;
                imm_o     = imm_u_fmt;
                use_imm_o = 1'b1;
                wreg_o    = 1'b1;
            end
            op_imm:
            begin
                opcode_o  = op_imm;
                use_imm_o = 1'b1;
                wreg_o    = 1'b1;
                case (funct3)
                    3'b000:  alu_op_o = alu_add;
                    3'b010:  alu_op_o = alu_slt;
                    3'b100:  alu_op_o = alu_xor;
                    3'b110:  alu_op_o = alu_or;
                    3'b111:  alu_op_o = alu_and;
                    default:
                    begin
                        // sltiu and the shifts
                        opcode_o = op_other;
                        wreg_o   = 1'b0;
                    end
                endcase
            end
            op_reg:
            begin
                if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000))
                begin
                    opcode_o = op_reg;
                    wreg_o   = 1'b1;
                    case (funct3)
                        3'b000:  alu_op_o = funct7[5] ? alu_sub : alu_add;
                        3'b010:  alu_op_o = alu_slt;
                        3'b100:  alu_op_o = alu_xor;
                        3'b110:  alu_op_o = alu_or;
                        3'b111:  alu_op_o = alu_and;
                        default:
                        begin
                            opcode_o = op_other;
                            wreg_o   = 1'b0;
                        end
                    endcase
                end
            end
            op_branch:
            begin
                // beq and bne only
                if (funct3 == 3'b000 || funct3 == 3'b001)
                begin
                    opcode_o    = op_branch;
                    imm_o       = imm_b_fmt;
                    is_branch_o = 1'b1;
                    branch_ne_o = funct3[0];
                end
            end
            op_jal:
            begin
                opcode_o  = op_jal;
                imm_o     = imm_j_fmt;
                use_imm_o = 1'b1;
                wreg_o    = 1'b1;
            end
            op_load:
            begin
                if (funct3 == 3'b010)
                begin
                    opcode_o  = op_load;
                    use_imm_o = 1'b1;
                    wreg_o    = 1'b1;
                end
            end
            op_store:
            begin
                if (funct3 == 3'b010)
                begin
                    opcode_o  = op_store;
                    imm_o     = imm_s_fmt;
                    use_imm_o = 1'b1;
                end
            end
            default:
            begin
                opcode_o = op_other;
            end
        endcase
    end

endmodule

// File: design/regfile.sv
/* 32 x 32 register file, two asynchronous reads and one synchronous write */
module regfile #(
    parameter int data_w = rv_pkg::xlen,
    parameter int addr_w = rv_pkg::reg_addr_w
) (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              rdy_i,
    input  logic              we_i,
    input  logic [addr_w-1:0] waddr_i,
    input  logic [data_w-1:0] wdata_i,
    input  logic [addr_w-1:0] raddr1_i,
    input  logic [addr_w-1:0] raddr2_i,
    output logic [data_w-1:0] rdata1_o,
    output logic [data_w-1:0] rdata2_o
);

    // x0 has no storage
    logic [data_w-1:0] regs_q [1:2**addr_w-1];

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            for (int i = 1; i < 2**addr_w; i++)
                regs_q[i] <= '0;
        end
        else if (rdy_i && we_i && waddr_i != '0)
            regs_q[waddr_i] <= wdata_i;
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

    // a register written in one cycle reads back the new value in the next
    assert property (@(posedge clk_in) disable iff (rst_in)
        (rdy_i && we_i && waddr_i != '0) |=>
            (raddr1_i != $past(waddr_i) || rdata1_o == $past(wdata_i)));

endmodule

// File: design/rv_pkg.sv
/* Shared widths and enumerations of the multi-cycle RV32I core:
   major opcodes, ALU operations, control states and memory commands */
package rv_pkg;

    // data and address width
    localparam int xlen = 32;

    // register index width
    localparam int reg_addr_w = 5;

    // major opcodes, bits 6:0 of the instruction word
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_other  = 7'b0000000
    } opcode_e;

    // operations of the execute unit
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_xor,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // one instruction walks these states in order, st_mem only for lw and sw
    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_mem,
        st_writeback
    } cpu_state_e;

    // kind of word access on the byte port
    typedef enum logic {
        cmd_read,
        cmd_write
    } mem_cmd_e;

endpackage
